// ==== hw/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

    ////////////////////
    // Data widths

    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;

    ////////////////////
    // Pipeline shape

    localparam int NUM_ROUNDS   = 10;
    // Register depth of one round or key step
    localparam int STAGE_CYCLES = 2;
    // Input register plus all rounds
    localparam int CORE_LATENCY = 1 + NUM_ROUNDS * STAGE_CYCLES;

    ////////////////////
    // GF(2^8) arithmetic

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add product
    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t acc;
        byte_t cur;
        acc = '0;
        cur = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ cur;
            cur = xtime(cur);
        end
        return acc;
    endfunction

    // Field inverse as b^254, then the affine map
    function automatic byte_t sbox(byte_t b);
        byte_t inv;
        byte_t sq;
        inv = 8'h01;
        sq  = b;
        // b^254 is the product of b^2, b^4 ... b^128
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        return inv
            ^ {inv[6:0], inv[7]}
            ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]}
            ^ {inv[3:0], inv[7:4]}
            ^ 8'h63;
    endfunction

    // Round constant for rounds 1 to 10
    function automatic byte_t rcon(int unsigned round_idx);
        byte_t rc;
        rc = 8'h01;
        for (int i = 1; i < NUM_ROUNDS; i++)
        begin
            if (i < round_idx)
                rc = xtime(rc);
        end
        return rc;
    endfunction

endpackage

`default_nettype wire

// ==== hw/sbox_lookup.sv ====
`default_nettype none

module sbox_lookup
    import aes_pkg::*;
#(
    parameter bit mix_columns = 1'b1
)
(
    input  wire        clk,
    input  wire word_t word_in,
    output word_t [3:0] bytes_out
);

    byte_t [3:0] sub;

    // Byte 0 sits in the top bits of the word
    always_comb
    begin
        for (int k = 0; k < 4; k++)
        begin
            sub[k] = sbox(word_in[31 - 8 * k -: 8]);
        end
    end

    if (mix_columns)
    begin : g_tcol
        // Column of S, S, 3S, 2S per byte
        always_ff @(posedge clk)
        begin
            for (int k = 0; k < 4; k++)
            begin
                bytes_out[k] <= {sub[k], sub[k], xtime(sub[k]) ^ sub[k], xtime(sub[k])};
            end
        end
    end
    else
    begin : g_plain
        always_ff @(posedge clk)
        begin
            bytes_out[0]   <= {sub[0], sub[1], sub[2], sub[3]};
            bytes_out[3:1] <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/key_expand_stage.sv ====
`default_nettype none

module key_expand_stage
    import aes_pkg::*;
(
    input  wire         clk,
    input  wire block_t key_in,
    input  wire byte_t  round_const,
    output block_t      key_next,
    output block_t      round_key
);

    word_t       w [4];
    word_t       chain [4];
    word_t       chain_q [4];
    word_t [3:0] sub_lanes;
    word_t       sub_word;

    assign {w[0], w[1], w[2], w[3]} = key_in;

    // Running XOR of the words, rcon folded into the first
    always_comb
    begin
        chain[0] = w[0] ^ {round_const, 24'h000000};
        for (int i = 1; i < 4; i++)
        begin
            chain[i] = chain[i - 1] ^ w[i];
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            chain_q[i] <= chain[i];
        end
    end

    // RotWord then SubWord, ready alongside chain_q
    sbox_lookup #(
        .mix_columns(1'b0)
    ) u_sub (
        .clk       (clk),
        .word_in   ({w[3][23:0], w[3][31:24]}),
        .bytes_out (sub_lanes)
    );

    assign sub_word = sub_lanes[0];

    assign round_key = {chain_q[0] ^ sub_word,
                        chain_q[1] ^ sub_word,
                        chain_q[2] ^ sub_word,
                        chain_q[3] ^ sub_word};

    // Next stage starts one cycle later
    always_ff @(posedge clk)
    begin
        key_next <= round_key;
    end

endmodule

`default_nettype wire

// ==== hw/cipher_round.sv ====
`default_nettype none

module cipher_round
    import aes_pkg::*;
#(
    parameter bit final_round = 1'b0
)
(
    input  wire         clk,
    input  wire block_t state_in,
    input  wire block_t round_key,
    output block_t      state_out
);

    word_t [3:0] col_lanes [4];
    word_t       mixed [4];

    // Rotate a T column into place for byte row r
    function automatic word_t rot_lane(word_t w, int unsigned r);
        logic [63:0] twice;
        twice = {w, w} >> (8 * ((r + 1) % 4));
        return twice[31:0];
    endfunction

    for (genvar c = 0; c < 4; c++)
    begin : g_sub
        sbox_lookup #(
            .mix_columns(!final_round)
        ) u_sub (
            .clk       (clk),
            .word_in   (state_in[127 - 32 * c -: 32]),
            .bytes_out (col_lanes[c])
        );
    end

    // ShiftRows picks byte r of output column j from column j + r
    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            mixed[j] = '0;
            for (int r = 0; r < 4; r++)
            begin
                if (final_round)
                    mixed[j][31 - 8 * r -: 8] = col_lanes[(j + r) % 4][0][31 - 8 * r -: 8];
                else
                    mixed[j] = mixed[j] ^ rot_lane(col_lanes[(j + r) % 4][r], r);
            end
        end
    end

    // AddRoundKey
    always_ff @(posedge clk)
    begin
        state_out <= {mixed[0], mixed[1], mixed[2], mixed[3]} ^ round_key;
    end

endmodule

`default_nettype wire

// ==== hw/aes_core.sv ====
`default_nettype none

module aes_core
    import aes_pkg::*;
(
    input  wire         clk,
    input  wire         COUNTER,
    input  wire         in_valid,
    input  wire block_t plaintext,
    input  wire block_t key,
    output logic        out_valid,
    output block_t      ciphertext
);

    localparam int WARM_W = $clog2(CORE_LATENCY + 1);

    block_t whitened_q;
    block_t key0_q;
    block_t state_chain [NUM_ROUNDS + 1];
    block_t key_chain [NUM_ROUNDS];
    block_t round_keys [NUM_ROUNDS];

    logic [CORE_LATENCY-1:0] valid_pipe;
    logic [WARM_W-1:0]       warm_cnt;

    ////////////////////
    // Input register

    // Whitening with round key zero
    always_ff @(posedge clk)
    begin
        whitened_q <= plaintext ^ key;
        key0_q     <= key;
    end

    assign state_chain[0] = whitened_q;
    assign key_chain[0]   = key0_q;

    ////////////////////
    // Rounds and key schedule

    for (genvar i = 0; i < NUM_ROUNDS; i++)
    begin : g_round
        if (i < NUM_ROUNDS - 1)
        begin : g_key
            key_expand_stage u_key (
                .clk         (clk),
                .key_in      (key_chain[i]),
                .round_const (rcon(i + 1)),
                .key_next    (key_chain[i + 1]),
                .round_key   (round_keys[i])
            );
        end
        else
        begin : g_key_last
            // Nothing follows the last key
            key_expand_stage u_key (
                .clk         (clk),
                .key_in      (key_chain[i]),
                .round_const (rcon(i + 1)),
                .key_next    (),
                .round_key   (round_keys[i])
            );
        end

        cipher_round #(
            .final_round(i == NUM_ROUNDS - 1)
        ) u_round (
            .clk       (clk),
            .state_in  (state_chain[i]),
            .round_key (round_keys[i]),
            .state_out (state_chain[i + 1])
        );
    end

    assign ciphertext = state_chain[NUM_ROUNDS];

    ////////////////////
    // Valid tracking

    always_ff @(posedge clk or posedge COUNTER)
    begin
        if (COUNTER)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[CORE_LATENCY-2:0], in_valid};
    end

    assign out_valid = valid_pipe[CORE_LATENCY-1];

    // Cycles since reset, saturating once the pipe is refilled
    always_ff @(posedge clk or posedge COUNTER)
    begin
        if (COUNTER)
            warm_cnt <= '0;
        else if (warm_cnt != WARM_W'(CORE_LATENCY))
            warm_cnt <= warm_cnt + 1'b1;
    end

    ////////////////////
    // Checks

    a_in_valid_known : assert property (
        @(posedge clk) disable iff (COUNTER)
        !$isunknown(in_valid)
    ) else $error("in_valid is unknown");

    // Holds only once no reset lies inside the window
    a_valid_latency : assert property (
        @(posedge clk) disable iff (COUNTER)
        (warm_cnt == WARM_W'(CORE_LATENCY)) |-> (out_valid == $past(in_valid, CORE_LATENCY))
    ) else $error("out_valid does not follow in_valid by CORE_LATENCY");

endmodule

`default_nettype wire

// ==== testbench/aes_vectors.svh ====
`ifndef AES_VECTORS_SVH
`define AES_VECTORS_SVH

// Known-answer table, one row per block
// Row layout is key, plaintext, ciphertext
localparam int NUM_VECTORS = 7;

localparam logic [383:0] VEC_TABLE [NUM_VECTORS] = '{
    // FIPS-197 appendix C.1
    {128'h000102030405060708090a0b0c0d0e0f,
     128'h00112233445566778899aabbccddeeff,
     128'h69c4e0d86a7b0430d8cdb78070b4c55a},
    // FIPS-197 appendix B
    {128'h2b7e151628aed2a6abf7158809cf4f3c,
     128'h3243f6a8885a308d313198a2e0370734,
     128'h3925841d02dc09fbdc118597196a0b32},
    // All-zero key and plaintext
    {128'h00000000000000000000000000000000,
     128'h00000000000000000000000000000000,
     128'h66e94bd4ef8a2c3b884cfa59ca342b2e},
    // SP 800-38A ECB-AES128 blocks 1 to 4
    {128'h2b7e151628aed2a6abf7158809cf4f3c,
     128'h6bc1bee22e409f96e93d7e117393172a,
     128'h3ad77bb40d7a3660a89ecaf32466ef97},
    {128'h2b7e151628aed2a6abf7158809cf4f3c,
     128'hae2d8a571e03ac9c9eb76fac45af8e51,
     128'hf5d3d58503b9699de785895a96fdbaaf},
    {128'h2b7e151628aed2a6abf7158809cf4f3c,
     128'h30c81c46a35ce411e5fbc1191a0a52ef,
     128'h43b1cd7f598ece23881b00e3ed030688},
    {128'h2b7e151628aed2a6abf7158809cf4f3c,
     128'hf69f2445df4f9b17ad2b417be66c3710,
     128'h7b0c785e27e8ad3f8223207104725dd4}
};

`endif

// ==== testbench/aes_tb.sv ====
`default_nettype none

module aes_tb
    import aes_pkg::*;
;

    `include "aes_vectors.svh"

    // Lone block, one streamed table, two gapped passes and one block after reset
    localparam int EXPECTED_OUTPUTS = 1 + NUM_VECTORS + 2 * NUM_VECTORS + 1;

    logic   clk;
    logic   COUNTER;
    logic   in_valid;
    block_t plaintext;
    block_t key;
    logic   out_valid;
    block_t ciphertext;

    block_t      exp_ct_q [$];
    int          due_q [$];
    int          cycle_cnt;
    int          outputs_seen;
    logic [15:0] lfsr_state;
    int unsigned gap;

    aes_core dut0 (
        .clk        (clk),
        .COUNTER    (COUNTER),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // Helpers

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Galois form with taps at 16, 14, 13 and 11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int unsigned v);
        v = 0;
        for (int b = 0; b < n; b++)
        begin
            v = (v << 1) | {31'b0, lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // One clock of stimulus applied just after the edge
    task automatic drive_cycle(input bit valid, input int idx);
        @(posedge clk);
        #10;
        in_valid = valid;
        if (valid)
        begin
            key       = VEC_TABLE[idx][383:256];
            plaintext = VEC_TABLE[idx][255:128];
            exp_ct_q.push_back(VEC_TABLE[idx][127:0]);
            due_q.push_back(cycle_cnt + CORE_LATENCY);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (due_q.size() != 0)
        begin
            if (waited > CORE_LATENCY + 4)
                stop_on_error("timeout while waiting for the pipeline to drain");
            else
            begin
                drive_cycle(1'b0, 0);
                waited++;
            end
        end
    endtask

    // In-flight blocks are lost on reset
    task automatic pulse_reset();
        @(posedge clk);
        #10;
        in_valid = 1'b0;
        COUNTER  = 1'b1;
        exp_ct_q.delete();
        due_q.delete();
        repeat (2) @(posedge clk);
        #10;
        COUNTER = 1'b0;
    endtask

    ////////////////////
    // Scoreboard

    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
        begin
            if (exp_ct_q.size() == 0)
                stop_on_error("out_valid rose with no block in flight");
            else
            begin
                check_value("ciphertext", ciphertext, exp_ct_q.pop_front());
                check_value("out_valid cycle", 128'(cycle_cnt), 128'(due_q.pop_front()));
                outputs_seen++;
            end
        end
        else if (out_valid !== 1'b0)
            stop_on_error("out_valid is unknown");
        else if (due_q.size() != 0 && due_q[0] <= cycle_cnt)
            stop_on_error("an expected out_valid did not arrive");
    end

    ////////////////////
    // Stimulus

    initial
    begin
        COUNTER      = 1'b1;
        in_valid     = 1'b0;
        plaintext    = '0;
        key          = '0;
        cycle_cnt    = 0;
        outputs_seen = 0;
        lfsr_state   = 16'd24082;
        repeat (2) @(posedge clk);
        #10;
        COUNTER = 1'b0;

        // Lone block for the latency
        drive_cycle(1'b1, 0);
        wait_drain();

        // Back to back
        for (int i = 0; i < NUM_VECTORS; i++)
            drive_cycle(1'b1, i);
        wait_drain();

        // Gaps of 0 to 3 idle cycles
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int i = 0; i < NUM_VECTORS; i++)
            begin
                random_bits(2, gap);
                repeat (gap) drive_cycle(1'b0, 0);
                drive_cycle(1'b1, i);
            end
        end
        wait_drain();

        // Nothing may come out after a reset with blocks in flight
        for (int i = 0; i < 5; i++)
            drive_cycle(1'b1, i);
        repeat (6) drive_cycle(1'b0, 0);
        pulse_reset();
        repeat (CORE_LATENCY + 2) drive_cycle(1'b0, 0);
        drive_cycle(1'b1, NUM_VECTORS - 1);
        wait_drain();

        check_value("output count", 128'(outputs_seen), 128'(EXPECTED_OUTPUTS));
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== aes_t2100.f ====
+incdir+testbench
hw/aes_pkg.sv
hw/sbox_lookup.sv
hw/key_expand_stage.sv
hw/cipher_round.sv
hw/aes_core.sv
testbench/aes_tb.sv

// ==== Makefile ====
# Verilator build and run of the AES-128 pipeline testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run aes_tb, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f aes_t2100.f --top-module aes_tb -Mdir obj_dir
	./obj_dir/Vaes_tb | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
